// ==== hdl/fpu_consts.svh ====
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// Operand and result word layout
`define FPU_WORD_W 32
`define FPU_EXP_W  8
`define FPU_MANT_W 23

// Exponent bias for the 8-bit field
`define FPU_BIAS   127

// Command side
`define FPU_TAG_W  4
`define FPU_OP_W   2

`endif

// ==== hdl/fpu_pkg.sv ====
`include "fpu_consts.svh"

package fpu_pkg;

    // Opcode 3 is not a legal command
    typedef enum logic [`FPU_OP_W-1:0] {
        FPU_ADD = 0,
        FPU_SUB = 1,
        FPU_MUL = 2
    } fpu_op_e;

    // Sign, biased exponent, mantissa without hidden bit
    typedef struct packed {
        logic                   sign;
        logic [`FPU_EXP_W-1:0]  exp;
        logic [`FPU_MANT_W-1:0] mantis;
    } float_fields_t;

    // Buses carry raw, datapaths decode fields
    typedef union packed {
        logic [`FPU_WORD_W-1:0] raw;
        float_fields_t          fields;
    } float_word_t;

endpackage

// ==== hdl/fpu_dispatch.sv ====
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_dispatch (
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  fpu_pkg::fpu_op_e       cmd_op,
    input  logic [`FPU_WORD_W-1:0] cmd_a,
    input  logic [`FPU_WORD_W-1:0] cmd_b,
    input  logic [`FPU_TAG_W-1:0]  cmd_tag,
    output logic                   add_valid,
    input  logic                   add_ready,
    output logic [`FPU_WORD_W-1:0] add_a,
    output logic [`FPU_WORD_W-1:0] add_b,
    output logic [`FPU_TAG_W-1:0]  add_tag,
    output logic                   mul_valid,
    input  logic                   mul_ready,
    output logic [`FPU_WORD_W-1:0] mul_a,
    output logic [`FPU_WORD_W-1:0] mul_b,
    output logic [`FPU_TAG_W-1:0]  mul_tag
);
    fpu_pkg::float_word_t b_word;
    logic                 to_add;
    logic                 to_mul;

    always_comb begin
        to_add = 1'b0;
        to_mul = 1'b0;
        case (cmd_op)
            fpu_pkg::FPU_ADD, fpu_pkg::FPU_SUB: to_add = 1'b1;
            fpu_pkg::FPU_MUL:                   to_mul = 1'b1;
            default: ;
        endcase
    end

    // SUB is ADD with B negated
    always_comb begin
        b_word.raw = cmd_b;
        if (cmd_op == fpu_pkg::FPU_SUB) begin
            b_word.fields.sign = ~b_word.fields.sign;
        end
    end

    assign add_valid = cmd_valid && to_add;
    assign mul_valid = cmd_valid && to_mul;
    assign cmd_ready = (to_add && add_ready) || (to_mul && mul_ready);

    assign add_a   = cmd_a;
    assign add_b   = b_word.raw;
    assign add_tag = cmd_tag;
    assign mul_a   = cmd_a;
    assign mul_b   = cmd_b;
    assign mul_tag = cmd_tag;

    op_legal: assert final (!cmd_valid || cmd_op != {`FPU_OP_W{1'b1}})
        else $error("illegal opcode %0d on command stream", cmd_op);

endmodule

// ==== hdl/fp_add_pipe.sv ====
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fp_add_pipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`FPU_WORD_W-1:0] in_a,
    input  logic [`FPU_WORD_W-1:0] in_b,
    input  logic [`FPU_TAG_W-1:0]  in_tag,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`FPU_WORD_W-1:0] out_word,
    output logic [`FPU_TAG_W-1:0]  out_tag
);
    localparam int MW  = `FPU_MANT_W + 1;
    localparam int EW  = `FPU_EXP_W;
    localparam int LZW = $clog2(MW);

    fpu_pkg::float_word_t a_w, b_w, norm_w;

    logic v1, v2, v3;
    logic take1, take2, take3;

    logic [EW-1:0]  big_exp, exp_diff;
    logic [MW-1:0]  big_mant, small_mant, small_shft;
    logic           big_sign, small_sign;

    logic [EW-1:0]         s1_exp;
    logic [MW-1:0]         s1_big, s1_small;
    logic                  s1_big_sign, s1_small_sign;
    logic [`FPU_TAG_W-1:0] s1_tag;

    logic [MW:0]           sum;
    logic                  sum_sign;
    logic [EW-1:0]         s2_exp;
    logic [MW:0]           s2_sum;
    logic                  s2_sign;
    logic [`FPU_TAG_W-1:0] s2_tag;

    logic [LZW-1:0]         lead_zeros;
    logic                   found;
    logic [MW-1:0]          shifted;
    logic [`FPU_WORD_W-1:0] s3_word;
    logic [`FPU_TAG_W-1:0]  s3_tag;

    // A stage loads when it is empty or its content moves on
    assign take3    = !v3 || out_ready;
    assign take2    = !v2 || take3;
    assign take1    = !v1 || take2;
    assign in_ready = take1;

    // Smaller exponent operand shifted right to align
    always_comb begin
        a_w.raw = in_a;
        b_w.raw = in_b;
        if (a_w.fields.exp >= b_w.fields.exp) begin
            big_exp    = a_w.fields.exp;
            exp_diff   = a_w.fields.exp - b_w.fields.exp;
            big_mant   = {1'b1, a_w.fields.mantis};
            big_sign   = a_w.fields.sign;
            small_mant = {1'b1, b_w.fields.mantis};
            small_sign = b_w.fields.sign;
        end else begin
            big_exp    = b_w.fields.exp;
            exp_diff   = b_w.fields.exp - a_w.fields.exp;
            big_mant   = {1'b1, b_w.fields.mantis};
            big_sign   = b_w.fields.sign;
            small_mant = {1'b1, a_w.fields.mantis};
            small_sign = a_w.fields.sign;
        end
        if (exp_diff >= EW'(MW + 1)) begin
            small_shft = '0;
        end else begin
            small_shft = small_mant >> exp_diff;
        end
    end

    // Add magnitudes, or subtract the smaller from the larger
    always_comb begin
        if (s1_big_sign == s1_small_sign) begin
            sum      = {1'b0, s1_big} + {1'b0, s1_small};
            sum_sign = s1_big_sign;
        end else if (s1_big >= s1_small) begin
            sum      = {1'b0, s1_big} - {1'b0, s1_small};
            sum_sign = s1_big_sign;
        end else begin
            sum      = {1'b0, s1_small} - {1'b0, s1_big};
            sum_sign = s1_small_sign;
        end
    end

    // Zero magnitude normalizes to the all-zero word
    always_comb begin
        lead_zeros = '0;
        found      = 1'b0;
        for (int i = MW - 1; i >= 0; i--) begin
            if (!found && s2_sum[i]) begin
                lead_zeros = LZW'(MW - 1 - i);
                found      = 1'b1;
            end
        end
        shifted    = s2_sum[MW-1:0] << lead_zeros;
        norm_w.raw = '0;
        if (s2_sum[MW]) begin
            norm_w.fields.sign   = s2_sign;
            norm_w.fields.exp    = s2_exp + 1'b1;
            norm_w.fields.mantis = s2_sum[MW-1:1];
        end else if (found) begin
            norm_w.fields.sign   = s2_sign;
            norm_w.fields.exp    = s2_exp - EW'(lead_zeros);
            norm_w.fields.mantis = shifted[MW-2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            if (take1) v1 <= in_valid;
            if (take2) v2 <= v1;
            if (take3) v3 <= v2;
        end
    end

    always_ff @(posedge clk) begin
        if (take1 && in_valid) begin
            s1_exp        <= big_exp;
            s1_big        <= big_mant;
            s1_small      <= small_shft;
            s1_big_sign   <= big_sign;
            s1_small_sign <= small_sign;
            s1_tag        <= in_tag;
        end
        if (take2 && v1) begin
            s2_exp  <= s1_exp;
            s2_sum  <= sum;
            s2_sign <= sum_sign;
            s2_tag  <= s1_tag;
        end
        if (take3 && v2) begin
            s3_word <= norm_w.raw;
            s3_tag  <= s2_tag;
        end
    end

    assign out_valid = v3;
    assign out_word  = s3_word;
    assign out_tag   = s3_tag;

    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_word) && $stable(out_tag));

    out_clear: assert property (@(posedge clk) reset |=> !out_valid);

endmodule

// ==== hdl/fp_mul_pipe.sv ====
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fp_mul_pipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`FPU_WORD_W-1:0] in_a,
    input  logic [`FPU_WORD_W-1:0] in_b,
    input  logic [`FPU_TAG_W-1:0]  in_tag,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`FPU_WORD_W-1:0] out_word,
    output logic [`FPU_TAG_W-1:0]  out_tag
);
    localparam int MW = `FPU_MANT_W + 1;
    localparam int PW = 2 * MW;
    localparam int EW = `FPU_EXP_W;

    fpu_pkg::float_word_t a_w, b_w, norm_w;

    logic v1, v2;
    logic take1, take2;

    logic [PW-1:0] product;
    logic [EW-1:0] prod_exp;
    logic          prod_sign;

    logic [PW-1:0]          s1_prod;
    logic [EW-1:0]          s1_exp;
    logic                   s1_sign;
    logic [`FPU_TAG_W-1:0]  s1_tag;
    logic [`FPU_WORD_W-1:0] s2_word;
    logic [`FPU_TAG_W-1:0]  s2_tag;

    assign take2    = !v2 || out_ready;
    assign take1    = !v1 || take2;
    assign in_ready = take1;

    // Exponent wraps in 8 bits; the true value stays in range
    always_comb begin
        a_w.raw   = in_a;
        b_w.raw   = in_b;
        product   = {1'b1, a_w.fields.mantis} * {1'b1, b_w.fields.mantis};
        prod_exp  = a_w.fields.exp + b_w.fields.exp - EW'(`FPU_BIAS);
        prod_sign = a_w.fields.sign ^ b_w.fields.sign;
    end

    // Product lies in [1,4) so one normalize step suffices
    always_comb begin
        norm_w.fields.sign = s1_sign;
        if (s1_prod[PW-1]) begin
            norm_w.fields.exp    = s1_exp + 1'b1;
            norm_w.fields.mantis = s1_prod[PW-2 -: `FPU_MANT_W];
        end else begin
            norm_w.fields.exp    = s1_exp;
            norm_w.fields.mantis = s1_prod[PW-3 -: `FPU_MANT_W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            if (take1) v1 <= in_valid;
            if (take2) v2 <= v1;
        end
    end

    always_ff @(posedge clk) begin
        if (take1 && in_valid) begin
            s1_prod <= product;
            s1_exp  <= prod_exp;
            s1_sign <= prod_sign;
            s1_tag  <= in_tag;
        end
        if (take2 && v1) begin
            s2_word <= norm_w.raw;
            s2_tag  <= s1_tag;
        end
    end

    assign out_valid = v2;
    assign out_word  = s2_word;
    assign out_tag   = s2_tag;

    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_word) && $stable(out_tag));

endmodule

// ==== hdl/result_arbiter.sv ====
`timescale 1ns/1ns
`include "fpu_consts.svh"

module result_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   aout_valid,
    output logic                   aout_ready,
    input  logic [`FPU_WORD_W-1:0] aout_word,
    input  logic [`FPU_TAG_W-1:0]  aout_tag,
    input  logic                   mout_valid,
    output logic                   mout_ready,
    input  logic [`FPU_WORD_W-1:0] mout_word,
    input  logic [`FPU_TAG_W-1:0]  mout_tag,
    output logic                   res_valid,
    input  logic                   res_ready,
    output logic [`FPU_WORD_W-1:0] res_word,
    output logic [`FPU_TAG_W-1:0]  res_tag
);
    logic load;
    logic grant_a;
    logic grant_m;
    logic last_was_mul;

    // Output register free this cycle
    assign load = !res_valid || res_ready;

    // On contention the unit that lost last time wins
    assign grant_a = aout_valid && (!mout_valid || last_was_mul);
    assign grant_m = mout_valid && !grant_a;

    assign aout_ready = load && grant_a;
    assign mout_ready = load && grant_m;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid    <= 1'b0;
            last_was_mul <= 1'b0;
        end else if (load) begin
            res_valid <= grant_a || grant_m;
            if (grant_a) begin
                last_was_mul <= 1'b0;
            end else if (grant_m) begin
                last_was_mul <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aout_ready) begin
            res_word <= aout_word;
            res_tag  <= aout_tag;
        end else if (mout_ready) begin
            res_word <= mout_word;
            res_tag  <= mout_tag;
        end
    end

    one_grant: assert property (@(posedge clk) disable iff (reset)
        !(aout_ready && mout_ready));

endmodule

// ==== hdl/fpu_cluster.sv ====
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_cluster (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  fpu_pkg::fpu_op_e       cmd_op,
    input  logic [`FPU_WORD_W-1:0] cmd_a,
    input  logic [`FPU_WORD_W-1:0] cmd_b,
    input  logic [`FPU_TAG_W-1:0]  cmd_tag,
    output logic                   res_valid,
    input  logic                   res_ready,
    output logic [`FPU_WORD_W-1:0] res_word,
    output logic [`FPU_TAG_W-1:0]  res_tag
);
    // Dispatch to units
    logic                   add_valid, add_ready;
    logic [`FPU_WORD_W-1:0] add_a, add_b;
    logic [`FPU_TAG_W-1:0]  add_tag;
    logic                   mul_valid, mul_ready;
    logic [`FPU_WORD_W-1:0] mul_a, mul_b;
    logic [`FPU_TAG_W-1:0]  mul_tag;

    // Units to arbiter
    logic                   aout_valid, aout_ready;
    logic [`FPU_WORD_W-1:0] aout_word;
    logic [`FPU_TAG_W-1:0]  aout_tag;
    logic                   mout_valid, mout_ready;
    logic [`FPU_WORD_W-1:0] mout_word;
    logic [`FPU_TAG_W-1:0]  mout_tag;

    fpu_dispatch u_dispatch (
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_a     (cmd_a),
        .cmd_b     (cmd_b),
        .cmd_tag   (cmd_tag),
        .add_valid (add_valid),
        .add_ready (add_ready),
        .add_a     (add_a),
        .add_b     (add_b),
        .add_tag   (add_tag),
        .mul_valid (mul_valid),
        .mul_ready (mul_ready),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .mul_tag   (mul_tag)
    );

    fp_add_pipe u_add (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (add_valid),
        .in_ready  (add_ready),
        .in_a      (add_a),
        .in_b      (add_b),
        .in_tag    (add_tag),
        .out_valid (aout_valid),
        .out_ready (aout_ready),
        .out_word  (aout_word),
        .out_tag   (aout_tag)
    );

    fp_mul_pipe u_mul (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .in_a      (mul_a),
        .in_b      (mul_b),
        .in_tag    (mul_tag),
        .out_valid (mout_valid),
        .out_ready (mout_ready),
        .out_word  (mout_word),
        .out_tag   (mout_tag)
    );

    result_arbiter u_arb (
        .clk        (clk),
        .reset      (reset),
        .aout_valid (aout_valid),
        .aout_ready (aout_ready),
        .aout_word  (aout_word),
        .aout_tag   (aout_tag),
        .mout_valid (mout_valid),
        .mout_ready (mout_ready),
        .mout_word  (mout_word),
        .mout_tag   (mout_tag),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_word   (res_word),
        .res_tag    (res_tag)
    );

endmodule

// ==== verif/fpu_cluster_tb.sv ====
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_cluster_tb;

    localparam int N_DIRECTED = 12;
    localparam int N_RANDOM   = 100;
    localparam int N_STALL    = 150;
    localparam int TOTAL      = N_DIRECTED + N_RANDOM + N_STALL;
    localparam int LIMIT_CYC  = TOTAL * 50 + 100;
    localparam int NUM_TAGS   = 1 << `FPU_TAG_W;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   cmd_valid;
    logic                   cmd_ready;
    fpu_pkg::fpu_op_e       cmd_op;
    logic [`FPU_WORD_W-1:0] cmd_a;
    logic [`FPU_WORD_W-1:0] cmd_b;
    logic [`FPU_TAG_W-1:0]  cmd_tag;
    logic                   res_valid;
    logic                   res_ready;
    logic [`FPU_WORD_W-1:0] res_word;
    logic [`FPU_TAG_W-1:0]  res_tag;

    // Scoreboard indexed by tag
    logic [`FPU_WORD_W-1:0] exp_word [NUM_TAGS];
    logic                   outstanding [NUM_TAGS];
    logic [`FPU_TAG_W-1:0]  next_tag;
    int                     answered;
    logic                   stall_mode;
    logic                   stall_seen;

    fpu_cluster UUT (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_a     (cmd_a),
        .cmd_b     (cmd_b),
        .cmd_tag   (cmd_tag),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_word  (res_word),
        .res_tag   (res_tag)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR at %0t: %s is %h, expected %h",
                                        $time, name, actual, expected));
        end
    endtask

    // Reference ADD on signed magnitudes with truncation
    function automatic logic [31:0] add_words(input logic [31:0] a, input logic [31:0] b);
        fpu_pkg::float_word_t wa, wb, r;
        longint ma, mb, sum, mag;
        int     ea, eb, e;
        wa.raw = a;
        wb.raw = b;
        ea = wa.fields.exp;
        eb = wb.fields.exp;
        ma = {1'b1, wa.fields.mantis};
        mb = {1'b1, wb.fields.mantis};
        if (ea >= eb) begin
            mb = (ea - eb > 24) ? 0 : mb >> (ea - eb);
            e  = ea;
        end else begin
            ma = (eb - ea > 24) ? 0 : ma >> (eb - ea);
            e  = eb;
        end
        if (wa.fields.sign) ma = -ma;
        if (wb.fields.sign) mb = -mb;
        sum   = ma + mb;
        r.raw = '0;
        if (sum != 0) begin
            r.fields.sign = (sum < 0);
            mag = (sum < 0) ? -sum : sum;
            if (mag >= (64'd1 << 24)) begin
                mag = mag >> 1;
                e   = e + 1;
            end
            while (mag < (64'd1 << 23)) begin
                mag = mag << 1;
                e   = e - 1;
            end
            r.fields.exp    = 8'(e);
            r.fields.mantis = mag[22:0];
        end
        return r.raw;
    endfunction

    function automatic logic [31:0] multiply_words(input logic [31:0] a, input logic [31:0] b);
        fpu_pkg::float_word_t wa, wb, r;
        longint prod;
        int     e;
        wa.raw = a;
        wb.raw = b;
        prod = longint'({1'b1, wa.fields.mantis}) * longint'({1'b1, wb.fields.mantis});
        e    = int'(wa.fields.exp) + int'(wb.fields.exp) - `FPU_BIAS;
        r.fields.sign = wa.fields.sign ^ wb.fields.sign;
        if (prod[47]) begin
            r.fields.exp    = 8'(e + 1);
            r.fields.mantis = prod[46:24];
        end else begin
            r.fields.exp    = 8'(e);
            r.fields.mantis = prod[45:23];
        end
        return r.raw;
    endfunction

    function automatic logic [31:0] predict_result(input fpu_pkg::fpu_op_e op,
                                                   input logic [31:0] a, input logic [31:0] b);
        case (op)
            fpu_pkg::FPU_ADD: return add_words(a, b);
            fpu_pkg::FPU_SUB: return add_words(a, {~b[31], b[30:0]});
            default:          return multiply_words(a, b);
        endcase
    endfunction

    // Exponent kept inside 64..190
    function automatic logic [31:0] random_operand(input int exp_val);
        fpu_pkg::float_word_t w;
        if (exp_val < 64) exp_val = 64;
        if (exp_val > 190) exp_val = 190;
        w.fields.sign   = 1'($urandom % 2);
        w.fields.exp    = 8'(exp_val);
        w.fields.mantis = 23'($urandom);
        return w.raw;
    endfunction

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic send_command(input fpu_pkg::fpu_op_e op, input logic [31:0] a,
                                input logic [31:0] b);
        logic [`FPU_TAG_W-1:0] tag;
        tag = next_tag;
        while (outstanding[tag]) begin
            @(negedge clk);
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_a     = a;
        cmd_b     = b;
        cmd_tag   = tag;
        #1;
        while (!cmd_ready) begin
            if (!res_ready) stall_seen = 1'b1;
            @(negedge clk);
            #1;
        end
        exp_word[tag]    = predict_result(op, a, b);
        outstanding[tag] = 1'b1;
        next_tag         = tag + 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_random(input int count);
        fpu_pkg::fpu_op_e op;
        logic [31:0]      a;
        int               ea;
        for (int i = 0; i < count; i++) begin
            op = fpu_pkg::fpu_op_e'($urandom % 3);
            ea = 64 + $urandom % 127;
            a  = random_operand(ea);
            // Close exponents half the time to provoke cancellation
            if (op != fpu_pkg::FPU_MUL && ($urandom % 2) == 1) begin
                send_command(op, a, random_operand(ea + int'($urandom % 5) - 2));
            end else begin
                send_command(op, a, random_operand(64 + $urandom % 127));
            end
        end
    endtask

    // res_ready policy and the result checker
    initial begin : result_side
        int low_left;
        low_left = 0;
        forever begin
            @(negedge clk);
            if (!stall_mode) begin
                res_ready = 1'b1;
            end else if (low_left > 0) begin
                res_ready = 1'b0;
                low_left  = low_left - 1;
            end else if ($urandom % 16 == 0) begin
                low_left  = 20 + $urandom % 21;
                res_ready = 1'b0;
            end else begin
                res_ready = 1'($urandom % 2);
            end
            if (!reset && res_valid && res_ready) begin
                if (!outstanding[res_tag]) begin
                    stop_with_failure($sformatf(
                        "result for tag %0d arrived with no command outstanding",
                        res_tag));
                end else begin
                    check_value("res_word", res_word, exp_word[res_tag]);
                    outstanding[res_tag] = 1'b0;
                    answered = answered + 1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYC) @(posedge clk);
        stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d results back",
                                    LIMIT_CYC, answered, TOTAL));
    end

    initial begin : main
        void'($urandom(22777));
        reset      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = fpu_pkg::FPU_ADD;
        cmd_a      = '0;
        cmd_b      = '0;
        cmd_tag    = '0;
        res_ready  = 1'b1;
        next_tag   = '0;
        answered   = 0;
        stall_mode = 1'b0;
        stall_seen = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            outstanding[t] = 1'b0;
            exp_word[t]    = '0;
        end

        repeat (8) begin
            @(negedge clk);
            check_value("res_valid", res_valid, 0);
        end
        reset = 1'b0;
        @(negedge clk);
        check_value("res_valid", res_valid, 0);
        check_value("cmd_ready", cmd_ready, 1);

        // ADD with carry out, unequal exponents and a shift past the mantissa
        send_command(fpu_pkg::FPU_ADD, 32'h3FC0_0000, 32'h3FC0_0000);
        send_command(fpu_pkg::FPU_ADD, 32'h3F80_0000, 32'h3F40_0000);
        send_command(fpu_pkg::FPU_ADD, 32'h4040_0000, 32'h3E00_0000);
        send_command(fpu_pkg::FPU_ADD, 32'h4C80_0000, 32'h3F80_0000);
        // SUB with deep cancellation, B sign winning and an exact zero
        send_command(fpu_pkg::FPU_SUB, 32'h3F80_0001, 32'h3F80_0000);
        send_command(fpu_pkg::FPU_SUB, 32'h3F80_0000, 32'h4040_0000);
        send_command(fpu_pkg::FPU_SUB, 32'h4020_0000, 32'h4020_0000);
        send_command(fpu_pkg::FPU_ADD, 32'h3FC0_0000, 32'hBFE0_0000);
        // MUL products above and below two
        send_command(fpu_pkg::FPU_MUL, 32'h3FC0_0000, 32'h3FC0_0000);
        send_command(fpu_pkg::FPU_MUL, 32'h3FA0_0000, 32'hBFA0_0000);
        send_command(fpu_pkg::FPU_MUL, 32'hC040_0000, 32'hBF00_0000);
        send_command(fpu_pkg::FPU_MUL, 32'h3FE0_0000, 32'hC0E0_0000);

        send_random(N_RANDOM);
        stall_mode = 1'b1;
        send_random(N_STALL);

        while (answered != TOTAL) begin
            @(negedge clk);
        end
        if (stall_seen) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("cmd_ready never fell while the result stream was stalled");
        end
    end

endmodule

// ==== fpu_cluster.f ====
+incdir+hdl
hdl/fpu_pkg.sv
hdl/fpu_dispatch.sv
hdl/fp_add_pipe.sv
hdl/fp_mul_pipe.sv
hdl/result_arbiter.sv
hdl/fpu_cluster.sv
verif/fpu_cluster_tb.sv

// ==== Bender.yml ====
package:
  name: fpu_cluster

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fpu_pkg.sv
      - hdl/fpu_dispatch.sv
      - hdl/fp_add_pipe.sv
      - hdl/fp_mul_pipe.sv
      - hdl/result_arbiter.sv
      - hdl/fpu_cluster.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/fpu_cluster_tb.sv
